//--- include/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Stage-time encoding used by the stall logic
`define CTRL_T_WIDTH 3
`define CTRL_T_0 3'd0
`define CTRL_T_1 3'd1
`define CTRL_T_2 3'd2
`define CTRL_T_INF 3'd3 // Operand never needed early

// Exception codes
`define CTRL_EXC_RI 5'd10
`define CTRL_EXC_SYSCALL 5'd8

`define CTRL_RA 5'd31 // Link register for jal

// Primary opcodes
`define CTRL_OP_SPECIAL 6'b000000
`define CTRL_OP_COP0 6'b010000
`define CTRL_OP_ADDI 6'b001000
`define CTRL_OP_ANDI 6'b001100
`define CTRL_OP_ORI 6'b001101
`define CTRL_OP_LUI 6'b001111
`define CTRL_OP_LW 6'b100011
`define CTRL_OP_LH 6'b100001
`define CTRL_OP_LB 6'b100000
`define CTRL_OP_SW 6'b101011
`define CTRL_OP_SH 6'b101001
`define CTRL_OP_SB 6'b101000
`define CTRL_OP_BEQ 6'b000100
`define CTRL_OP_BNE 6'b000101
`define CTRL_OP_JAL 6'b000011

// Function field of special-opcode words
`define CTRL_FN_ADD 6'b100000
`define CTRL_FN_SUB 6'b100010
`define CTRL_FN_AND 6'b100100
`define CTRL_FN_OR 6'b100101
`define CTRL_FN_SLT 6'b101010
`define CTRL_FN_SLTU 6'b101011
`define CTRL_FN_SLL 6'b000000
`define CTRL_FN_JR 6'b001000
`define CTRL_FN_SYSCALL 6'b001100
`define CTRL_FN_MULT 6'b011000
`define CTRL_FN_MULTU 6'b011001
`define CTRL_FN_DIV 6'b011010
`define CTRL_FN_DIVU 6'b011011
`define CTRL_FN_MFHI 6'b010000
`define CTRL_FN_MTHI 6'b010001
`define CTRL_FN_MFLO 6'b010010
`define CTRL_FN_MTLO 6'b010011

// COP0 words: eret needs bit 25 set as well
`define CTRL_FN_ERET 6'b011000

// CP0 sub-opcodes in the rs field
`define CTRL_RS_MFC0 5'b00000
`define CTRL_RS_MTC0 5'b00100

`endif

//--- hdl/ctrl_pkg.sv
`default_nettype none

`include "ctrl_config.svh"

package ctrl_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } insn_t;

    // One flag per supported instruction
    typedef struct packed {
        logic is_add, is_sub, is_and, is_or;
        logic is_slt, is_sltu, is_sll, is_jr;
        logic is_addi, is_andi, is_ori, is_lui;
        logic is_lw, is_lh, is_lb;
        logic is_sw, is_sh, is_sb;
        logic is_beq, is_bne, is_jal;
        logic is_mult, is_multu, is_div, is_divu;
        logic is_mfhi, is_mflo, is_mthi, is_mtlo;
        logic is_mfc0, is_mtc0, is_eret, is_syscall;
    } insn_class_t;

    typedef enum logic [2:0] {
        alu_and = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_or  = 3'd3,
        alu_sll = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {npc_norm, npc_branch, npc_j26, npc_j32} npc_op_e;

    typedef enum logic [1:0] {cond_eq, cond_ne, cond_uncond} npc_cond_e;

    typedef enum logic [1:0] {dm_word, dm_half, dm_byte} dm_size_e;

    typedef enum logic {alu_b_reg_rd2, alu_b_ext_imm} alu_b_sel_e;

    typedef enum logic {alu_sa_shamt, alu_sa_sixteen} alu_sa_sel_e; // sixteen for lui

    typedef enum logic [1:0] {a3_rd, a3_rt, a3_ra} grf_a3_sel_e;

    typedef enum logic [2:0] {
        wd_alu, wd_dm, wd_pc_8, wd_set, wd_hi, wd_lo, wd_cp0
    } grf_wd_sel_e;

    typedef enum logic [2:0] {fwd_alu, fwd_pc_8, fwd_set, fwd_hi, fwd_lo} fwd_src_e;

    typedef struct packed {
        alu_op_e     alu_op;
        alu_b_sel_e  alu_b_sel;
        alu_sa_sel_e alu_sa_sel;
        logic        ext_signed;
        logic        alu_overflow_chk;
        logic        alu_load;
        logic        alu_store;
        logic        cmp_signed;
        npc_op_e     npc_op;
        npc_cond_e   npc_cond;
        logic        dm_we;
        dm_size_e    dm_size;
        logic        dm_ext_signed;
        logic        md_start;
        logic        md_is_mult; // Else divide
        logic        md_signed;
        logic        md_write;   // mthi or mtlo
        logic        md_write_hi;
        logic        read_hi;
        logic        read_lo;
        logic        grf_we;
        grf_a3_sel_e grf_a3_sel;
        grf_wd_sel_e grf_wd_sel;
        logic        cp0_we;
        logic        eret;
    } datapath_ctrl_t;

    typedef struct packed {
        logic [`CTRL_T_WIDTH-1:0] t_use_rd1;
        logic [`CTRL_T_WIDTH-1:0] t_use_rd2;
        logic [`CTRL_T_WIDTH-1:0] t_new;
        logic [4:0]               target;
        logic                     fwd_e;
        logic                     fwd_m;
        logic                     fwd_w;
        fwd_src_e                 fwd_src;       // Source seen from M onwards
        logic                     fwd_src_e_pc8; // E stage forwards pc_8, else set
        logic                     fwd_cp0;
    } hazard_info_t;

    typedef struct packed {
        logic       exception;
        logic [4:0] exc_code;
    } exc_t;

endpackage

`default_nettype wire

//--- hdl/insn_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module insn_decode import ctrl_pkg::*; (
    input  insn_t       insn,
    output insn_class_t cls,
    output exc_t        exc
);

    logic special;
    logic cop0;
    logic known;

    assign special = (insn.opcode == `CTRL_OP_SPECIAL);
    assign cop0    = (insn.opcode == `CTRL_OP_COP0);

    always_comb begin
        // Register form, selected by funct
        cls.is_add     = special & (insn.funct == `CTRL_FN_ADD);
        cls.is_sub     = special & (insn.funct == `CTRL_FN_SUB);
        cls.is_and     = special & (insn.funct == `CTRL_FN_AND);
        cls.is_or      = special & (insn.funct == `CTRL_FN_OR);
        cls.is_slt     = special & (insn.funct == `CTRL_FN_SLT);
        cls.is_sltu    = special & (insn.funct == `CTRL_FN_SLTU);
        cls.is_sll     = special & (insn.funct == `CTRL_FN_SLL); // Includes nop
        cls.is_jr      = special & (insn.funct == `CTRL_FN_JR);
        cls.is_syscall = special & (insn.funct == `CTRL_FN_SYSCALL);

        // Multiply-divide unit
        cls.is_mult    = special & (insn.funct == `CTRL_FN_MULT);
        cls.is_multu   = special & (insn.funct == `CTRL_FN_MULTU);
        cls.is_div     = special & (insn.funct == `CTRL_FN_DIV);
        cls.is_divu    = special & (insn.funct == `CTRL_FN_DIVU);
        cls.is_mfhi    = special & (insn.funct == `CTRL_FN_MFHI);
        cls.is_mflo    = special & (insn.funct == `CTRL_FN_MFLO);
        cls.is_mthi    = special & (insn.funct == `CTRL_FN_MTHI);
        cls.is_mtlo    = special & (insn.funct == `CTRL_FN_MTLO);

        cls.is_addi    = (insn.opcode == `CTRL_OP_ADDI);
        cls.is_andi    = (insn.opcode == `CTRL_OP_ANDI);
        cls.is_ori     = (insn.opcode == `CTRL_OP_ORI);
        cls.is_lui     = (insn.opcode == `CTRL_OP_LUI);

        // Loads and stores
        cls.is_lw      = (insn.opcode == `CTRL_OP_LW);
        cls.is_lh      = (insn.opcode == `CTRL_OP_LH);
        cls.is_lb      = (insn.opcode == `CTRL_OP_LB);
        cls.is_sw      = (insn.opcode == `CTRL_OP_SW);
        cls.is_sh      = (insn.opcode == `CTRL_OP_SH);
        cls.is_sb      = (insn.opcode == `CTRL_OP_SB);

        cls.is_beq     = (insn.opcode == `CTRL_OP_BEQ);
        cls.is_bne     = (insn.opcode == `CTRL_OP_BNE);
        cls.is_jal     = (insn.opcode == `CTRL_OP_JAL);

        // COP0 words decode on rs, eret on bit 25 and funct
        cls.is_mfc0    = cop0 & (insn.rs == `CTRL_RS_MFC0);
        cls.is_mtc0    = cop0 & (insn.rs == `CTRL_RS_MTC0);
        cls.is_eret    = cop0 & insn.rs[4] & (insn.funct == `CTRL_FN_ERET);
    end

    assign known = |cls;

    always_comb begin
        exc.exception = !known | cls.is_syscall;
        if (!known) begin
            exc.exc_code = `CTRL_EXC_RI;
        end else if (cls.is_syscall) begin
            exc.exc_code = `CTRL_EXC_SYSCALL;
        end else begin
            exc.exc_code = `CTRL_EXC_RI; // Don't care, flag is low
        end
    end

endmodule

`default_nettype wire

//--- hdl/datapath_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module datapath_ctrl import ctrl_pkg::*; (
    input  insn_class_t    cls,
    output datapath_ctrl_t dp_ctrl
);

    logic mem_read;
    logic mem_write;
    logic memory;
    logic mem_half;
    logic mem_byte;
    logic branch;
    logic jump;
    logic link;
    logic set;
    logic calc_and;
    logic calc_add;
    logic calc_sub;
    logic calc_or;
    logic calc_sll;
    logic calc_imm16;
    logic md_mult;
    logic md_div;
    logic md_write;
    logic grf_we_n;

    assign mem_read  = cls.is_lw | cls.is_lh | cls.is_lb;
    assign mem_write = cls.is_sw | cls.is_sh | cls.is_sb;
    assign memory    = mem_read | mem_write;
    assign mem_half  = cls.is_lh | cls.is_sh;
    assign mem_byte  = cls.is_lb | cls.is_sb;

    assign branch = cls.is_beq | cls.is_bne;
    assign jump   = cls.is_jal | cls.is_jr;
    assign link   = cls.is_jal;
    assign set    = cls.is_slt | cls.is_sltu;

    // ALU operation categories, address calculation counts as add
    assign calc_and   = cls.is_and | cls.is_andi;
    assign calc_add   = cls.is_add | cls.is_addi | memory;
    assign calc_sub   = cls.is_sub;
    assign calc_or    = cls.is_or | cls.is_ori;
    assign calc_sll   = cls.is_sll | cls.is_lui;
    assign calc_imm16 = cls.is_andi | cls.is_addi | cls.is_ori | cls.is_lui | memory;

    assign md_mult  = cls.is_mult | cls.is_multu;
    assign md_div   = cls.is_div | cls.is_divu;
    assign md_write = cls.is_mthi | cls.is_mtlo;

    assign grf_we_n = mem_write | branch | cls.is_jr | md_mult | md_div | md_write
                    | cls.is_mtc0 | cls.is_eret;

    always_comb begin
        dp_ctrl.alu_op = calc_and ? alu_and :
                         calc_add ? alu_add :
                         calc_sub ? alu_sub :
                         calc_or  ? alu_or  :
                         calc_sll ? alu_sll : alu_add;
        dp_ctrl.alu_b_sel  = calc_imm16 ? alu_b_ext_imm : alu_b_reg_rd2;
        dp_ctrl.alu_sa_sel = cls.is_lui ? alu_sa_sixteen : alu_sa_shamt;
        dp_ctrl.ext_signed = memory | cls.is_addi; // Offsets are signed too
        dp_ctrl.alu_overflow_chk = cls.is_add | cls.is_addi | cls.is_sub;
        dp_ctrl.alu_load  = mem_read;
        dp_ctrl.alu_store = mem_write;

        // Branch compare and next PC
        dp_ctrl.cmp_signed = branch | jump | cls.is_slt;
        dp_ctrl.npc_op = branch       ? npc_branch :
                         cls.is_jal   ? npc_j26    :
                         cls.is_jr    ? npc_j32    : npc_norm;
        dp_ctrl.npc_cond = jump       ? cond_uncond :
                           cls.is_bne ? cond_ne     : cond_eq;

        dp_ctrl.dm_we   = mem_write;
        dp_ctrl.dm_size = mem_byte ? dm_byte :
                          mem_half ? dm_half : dm_word;
        dp_ctrl.dm_ext_signed = cls.is_lb | cls.is_lh;

        dp_ctrl.md_start    = md_mult | md_div;
        dp_ctrl.md_is_mult  = md_mult;
        dp_ctrl.md_signed   = cls.is_mult | cls.is_div;
        dp_ctrl.md_write    = md_write;
        dp_ctrl.md_write_hi = cls.is_mthi;
        dp_ctrl.read_hi     = cls.is_mfhi;
        dp_ctrl.read_lo     = cls.is_mflo;

        dp_ctrl.grf_we = !grf_we_n;
        dp_ctrl.grf_a3_sel = link                      ? a3_ra :
                             (calc_imm16 | cls.is_mfc0) ? a3_rt : a3_rd;
        dp_ctrl.grf_wd_sel = cls.is_mfhi ? wd_hi   :
                             cls.is_mflo ? wd_lo   :
                             mem_read    ? wd_dm   :
                             link        ? wd_pc_8 :
                             set         ? wd_set  :
                             cls.is_mfc0 ? wd_cp0  : wd_alu;

        dp_ctrl.cp0_we = cls.is_mtc0;
        dp_ctrl.eret   = cls.is_eret;
    end

endmodule

`default_nettype wire

//--- hdl/hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module hazard_ctrl import ctrl_pkg::*; (
    input  insn_class_t  cls,
    input  insn_t        insn,
    output hazard_info_t hazard
);

    logic mem_read;
    logic mem_write;
    logic memory;
    logic calc;
    logic calc_imm16;
    logic imm_alu;
    logic set;
    logic link;
    logic md_arith;
    logic md_write;
    logic md_read;
    logic no_reg;

    assign mem_read  = cls.is_lw | cls.is_lh | cls.is_lb;
    assign mem_write = cls.is_sw | cls.is_sh | cls.is_sb;
    assign memory    = mem_read | mem_write;

    assign imm_alu    = cls.is_andi | cls.is_addi | cls.is_ori;
    assign calc_imm16 = imm_alu | cls.is_lui | memory;
    assign calc = cls.is_add | cls.is_sub | cls.is_and | cls.is_or | cls.is_sll | calc_imm16;

    assign set  = cls.is_slt | cls.is_sltu;
    assign link = cls.is_jal;

    assign md_arith = cls.is_mult | cls.is_multu | cls.is_div | cls.is_divu;
    assign md_write = cls.is_mthi | cls.is_mtlo;
    assign md_read  = cls.is_mfhi | cls.is_mflo;

    // Reads no GPR at all
    assign no_reg = cls.is_lui | md_read | cls.is_syscall | cls.is_eret | cls.is_mfc0;

    always_comb begin
        // rs is needed in E by the ALU and MD unit, in D by compare and jr
        hazard.t_use_rd1 = (no_reg | cls.is_sll | cls.is_mtc0) ? `CTRL_T_INF :
                           (calc | md_arith | md_write)        ? `CTRL_T_1   : `CTRL_T_0;

        // Store data and mtc0 data are needed only in M
        hazard.t_use_rd2 = (mem_read | no_reg | md_write | imm_alu) ? `CTRL_T_INF :
                           (mem_write | cls.is_mtc0)                ? `CTRL_T_2   :
                           ((calc & !memory) | md_arith)            ? `CTRL_T_1   : `CTRL_T_0;

        hazard.t_new = (mem_read | cls.is_mfc0)  ? `CTRL_T_2 :
                       ((calc & !memory) | md_read) ? `CTRL_T_1 : `CTRL_T_0;

        hazard.target = ((calc & !calc_imm16) | set | md_read)   ? insn.rd  :
                        ((calc_imm16 & !mem_write) | cls.is_mfc0) ? insn.rt  :
                        link                                     ? `CTRL_RA : 5'd0;

        hazard.fwd_e = set | link;
        hazard.fwd_m = (calc & !memory) | link | set | md_read;
        hazard.fwd_w = (calc & !mem_write) | link | set | md_read | cls.is_mfc0;

        hazard.fwd_src = cls.is_mfhi      ? fwd_hi   :
                         cls.is_mflo      ? fwd_lo   :
                         set              ? fwd_set  :
                         (calc & !memory) ? fwd_alu  :
                         link             ? fwd_pc_8 : fwd_alu;
        hazard.fwd_src_e_pc8 = link;
        hazard.fwd_cp0 = cls.is_mtc0; // CP0 write data comes from the GPR file
    end

endmodule

`default_nettype wire

//--- hdl/mips_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mips_ctrl import ctrl_pkg::*; (
    input  insn_t          insn,
    output datapath_ctrl_t dp_ctrl,
    output hazard_info_t   hazard,
    output exc_t           exc
);

    insn_class_t cls; // One-hot, all zero for unknown words

    insn_decode insn_decode_i (
        .insn (insn),
        .cls  (cls),
        .exc  (exc)
    );

    datapath_ctrl datapath_ctrl_i (
        .cls     (cls),
        .dp_ctrl (dp_ctrl)
    );

    // Register fields come straight from the word
    hazard_ctrl hazard_ctrl_i (
        .cls    (cls),
        .insn   (insn),
        .hazard (hazard)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mips_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module tb_mips_ctrl import ctrl_pkg::*; ();

    localparam int REPEATS = 6;     // Vectors per kept instruction
    localparam int N_RANDOM = 200;
    localparam int MAX_CYCLES = 2000;
    localparam datapath_ctrl_t DP_ONES = '1;

    typedef enum int {
        i_add, i_sub, i_and, i_or, i_slt, i_sltu, i_sll, i_jr,
        i_addi, i_andi, i_ori, i_lui, i_lw, i_lh, i_lb, i_sw, i_sh, i_sb,
        i_beq, i_bne, i_jal, i_mult, i_multu, i_div, i_divu,
        i_mfhi, i_mflo, i_mthi, i_mtlo, i_mfc0, i_mtc0, i_eret, i_syscall,
        i_none
    } id_e;

    logic           clk = 1'b0;
    logic           rst_n;
    insn_t          insn;
    datapath_ctrl_t dp_ctrl;
    hazard_info_t   hazard;
    exc_t           exc;
    int             cycles = 0;
    int             dp_errors = 0;
    int             hz_errors = 0;
    int             exc_errors = 0;

    mips_ctrl mips_ctrl_i (
        .insn    (insn),
        .dp_ctrl (dp_ctrl),
        .hazard  (hazard),
        .exc     (exc)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic insn_t make_word(input id_e id);
        insn_t w;
        w = insn_t'($urandom); // Unused fields stay random
        case (id)
            i_add:     w.funct = `CTRL_FN_ADD;
            i_sub:     w.funct = `CTRL_FN_SUB;
            i_and:     w.funct = `CTRL_FN_AND;
            i_or:      w.funct = `CTRL_FN_OR;
            i_slt:     w.funct = `CTRL_FN_SLT;
            i_sltu:    w.funct = `CTRL_FN_SLTU;
            i_sll:     w.funct = `CTRL_FN_SLL;
            i_jr:      w.funct = `CTRL_FN_JR;
            i_syscall: w.funct = `CTRL_FN_SYSCALL;
            i_mult:    w.funct = `CTRL_FN_MULT;
            i_multu:   w.funct = `CTRL_FN_MULTU;
            i_div:     w.funct = `CTRL_FN_DIV;
            i_divu:    w.funct = `CTRL_FN_DIVU;
            i_mfhi:    w.funct = `CTRL_FN_MFHI;
            i_mflo:    w.funct = `CTRL_FN_MFLO;
            i_mthi:    w.funct = `CTRL_FN_MTHI;
            i_mtlo:    w.funct = `CTRL_FN_MTLO;
            default:   w.funct = w.funct;
        endcase
        case (id)
            i_addi:  w.opcode = `CTRL_OP_ADDI;
            i_andi:  w.opcode = `CTRL_OP_ANDI;
            i_ori:   w.opcode = `CTRL_OP_ORI;
            i_lui:   w.opcode = `CTRL_OP_LUI;
            i_lw:    w.opcode = `CTRL_OP_LW;
            i_lh:    w.opcode = `CTRL_OP_LH;
            i_lb:    w.opcode = `CTRL_OP_LB;
            i_sw:    w.opcode = `CTRL_OP_SW;
            i_sh:    w.opcode = `CTRL_OP_SH;
            i_sb:    w.opcode = `CTRL_OP_SB;
            i_beq:   w.opcode = `CTRL_OP_BEQ;
            i_bne:   w.opcode = `CTRL_OP_BNE;
            i_jal:   w.opcode = `CTRL_OP_JAL;
            i_mfc0, i_mtc0, i_eret: w.opcode = `CTRL_OP_COP0;
            default: w.opcode = `CTRL_OP_SPECIAL;
        endcase
        if (id == i_mfc0) w.rs = `CTRL_RS_MFC0;
        if (id == i_mtc0) w.rs = `CTRL_RS_MTC0;
        if (id == i_eret) begin
            w.rs[4] = 1'b1;
            w.funct = `CTRL_FN_ERET;
        end
        return w;
    endfunction

    // Reference table with one row per instruction
    function automatic datapath_ctrl_t dp_rule(input id_e id);
        datapath_ctrl_t e;
        e = '0;
        e.alu_op = alu_add;
        e.grf_we = 1'b1;
        case (id)
            i_add:  e.alu_overflow_chk = 1'b1;
            i_sub:  begin
                e.alu_op = alu_sub;
                e.alu_overflow_chk = 1'b1;
            end
            i_and:  e.alu_op = alu_and;
            i_or:   e.alu_op = alu_or;
            i_sll:  e.alu_op = alu_sll;
            i_addi: begin
                e.alu_b_sel = alu_b_ext_imm;
                e.ext_signed = 1'b1;
                e.alu_overflow_chk = 1'b1;
            end
            i_andi: begin
                e.alu_op = alu_and;
                e.alu_b_sel = alu_b_ext_imm;
            end
            i_ori:  begin
                e.alu_op = alu_or;
                e.alu_b_sel = alu_b_ext_imm;
            end
            i_lui:  begin
                e.alu_op = alu_sll;
                e.alu_b_sel = alu_b_ext_imm;
                e.alu_sa_sel = alu_sa_sixteen;
            end
            i_lw:   e.grf_wd_sel = wd_dm;
            i_lh:   begin
                e.dm_size = dm_half;
                e.dm_ext_signed = 1'b1;
                e.grf_wd_sel = wd_dm;
            end
            i_lb:   begin
                e.dm_size = dm_byte;
                e.dm_ext_signed = 1'b1;
                e.grf_wd_sel = wd_dm;
            end
            i_sw:   begin
                e.dm_we = 1'b1;
                e.grf_we = 1'b0;
            end
            i_sh:   begin
                e.dm_we = 1'b1;
                e.dm_size = dm_half;
                e.grf_we = 1'b0;
            end
            i_sb:   begin
                e.dm_we = 1'b1;
                e.dm_size = dm_byte;
                e.grf_we = 1'b0;
            end
            i_beq:  begin
                e.npc_op = npc_branch;
                e.grf_we = 1'b0;
            end
            i_bne:  begin
                e.npc_op = npc_branch;
                e.npc_cond = cond_ne;
                e.grf_we = 1'b0;
            end
            i_jal:  begin
                e.npc_op = npc_j26;
                e.npc_cond = cond_uncond;
                e.grf_wd_sel = wd_pc_8;
            end
            i_jr:   begin
                e.npc_op = npc_j32;
                e.npc_cond = cond_uncond;
                e.grf_we = 1'b0;
            end
            i_slt:  e.cmp_signed = 1'b1;
            i_mult, i_div: begin
                e.md_start = 1'b1;
                e.md_signed = 1'b1;
                e.grf_we = 1'b0;
            end
            i_multu, i_divu: begin
                e.md_start = 1'b1;
                e.grf_we = 1'b0;
            end
            i_mthi: begin
                e.md_write_hi = 1'b1;
                e.grf_we = 1'b0;
            end
            i_mtlo: e.grf_we = 1'b0;
            i_mfhi: e.read_hi = 1'b1;
            i_mflo: e.read_lo = 1'b1;
            i_mfc0: e.grf_wd_sel = wd_cp0;
            i_mtc0: begin
                e.cp0_we = 1'b1;
                e.grf_we = 1'b0;
            end
            i_eret: begin
                e.eret = 1'b1;
                e.grf_we = 1'b0;
            end
            default: e.grf_we = 1'b1; // Unknown words and syscall
        endcase
        return e;
    endfunction

    task automatic hazard_rule(input id_e id, input insn_t w,
                               output hazard_info_t e, output hazard_info_t m);
        e = '0;
        m = '0;
        m.target = '1;
        case (id)
            i_add, i_sub, i_and, i_or, i_sll, i_slt, i_sltu, i_mfhi, i_mflo: e.target = w.rd;
            i_addi, i_andi, i_ori, i_lui, i_lw, i_lh, i_lb, i_mfc0: e.target = w.rt;
            i_jal:   e.target = `CTRL_RA;
            default: e.target = 5'd0;
        endcase
        case (id)
            i_add, i_sub, i_and, i_or, i_sll, i_addi, i_andi, i_ori, i_lui, i_mfhi, i_mflo: begin
                e.t_new = `CTRL_T_1;
                m.t_new = '1;
            end
            i_lw, i_lh, i_lb, i_mfc0: begin
                e.t_new = `CTRL_T_2;
                m.t_new = '1;
            end
            default: e.t_new = `CTRL_T_0;
        endcase
        case (id)
            i_lw, i_lh, i_lb: begin
                e.t_use_rd2 = `CTRL_T_INF;
                m.t_use_rd2 = '1;
            end
            i_sw, i_sh, i_sb: begin
                e.t_use_rd2 = `CTRL_T_2;
                m.t_use_rd2 = '1;
                m.t_new = '1;
            end
            i_beq, i_bne, i_jr: m.fwd_e = 1'b1;
            i_jal:   begin
                e.fwd_e = 1'b1;
                m.fwd_e = 1'b1;
            end
            default: m.fwd_e = 1'b0;
        endcase
    endtask

    function automatic id_e classify(input insn_t w);
        case (w.opcode)
            `CTRL_OP_SPECIAL: begin
                case (w.funct)
                    `CTRL_FN_ADD: return i_add;
                    `CTRL_FN_SUB: return i_sub;
                    `CTRL_FN_AND: return i_and;
                    `CTRL_FN_OR: return i_or;
                    `CTRL_FN_SLT: return i_slt;
                    `CTRL_FN_SLTU: return i_sltu;
                    `CTRL_FN_SLL: return i_sll;
                    `CTRL_FN_JR: return i_jr;
                    `CTRL_FN_SYSCALL: return i_syscall;
                    `CTRL_FN_MULT: return i_mult;
                    `CTRL_FN_MULTU: return i_multu;
                    `CTRL_FN_DIV: return i_div;
                    `CTRL_FN_DIVU: return i_divu;
                    `CTRL_FN_MFHI: return i_mfhi;
                    `CTRL_FN_MFLO: return i_mflo;
                    `CTRL_FN_MTHI: return i_mthi;
                    `CTRL_FN_MTLO: return i_mtlo;
                    default: return i_none;
                endcase
            end
            `CTRL_OP_COP0: begin
                if (w.rs == `CTRL_RS_MFC0) return i_mfc0;
                if (w.rs == `CTRL_RS_MTC0) return i_mtc0;
                if (w.rs[4] && w.funct == `CTRL_FN_ERET) return i_eret;
                return i_none;
            end
            `CTRL_OP_ADDI: return i_addi;
            `CTRL_OP_ANDI: return i_andi;
            `CTRL_OP_ORI: return i_ori;
            `CTRL_OP_LUI: return i_lui;
            `CTRL_OP_LW: return i_lw;
            `CTRL_OP_LH: return i_lh;
            `CTRL_OP_LB: return i_lb;
            `CTRL_OP_SW: return i_sw;
            `CTRL_OP_SH: return i_sh;
            `CTRL_OP_SB: return i_sb;
            `CTRL_OP_BEQ: return i_beq;
            `CTRL_OP_BNE: return i_bne;
            `CTRL_OP_JAL: return i_jal;
            default: return i_none;
        endcase
    endfunction

    task automatic report_field(input string name, input string field,
                                input logic [63:0] got, input logic [63:0] exp);
        $display("Error at %0t ns: %s, %s is %0h, expected %0h", $time, name, field, got, exp);
    endtask

    task automatic check_dp(input datapath_ctrl_t g, input datapath_ctrl_t e,
                            input datapath_ctrl_t m, input string name);
        if ((g ^ e) & m) begin
            dp_errors++;
            if ((g.alu_op ^ e.alu_op) & m.alu_op) report_field(name, "alu_op", g.alu_op, e.alu_op);
            if ((g.alu_b_sel ^ e.alu_b_sel) & m.alu_b_sel)
                report_field(name, "alu_b_sel", g.alu_b_sel, e.alu_b_sel);
            if ((g.alu_sa_sel ^ e.alu_sa_sel) & m.alu_sa_sel)
                report_field(name, "alu_sa_sel", g.alu_sa_sel, e.alu_sa_sel);
            if ((g.npc_op ^ e.npc_op) & m.npc_op) report_field(name, "npc_op", g.npc_op, e.npc_op);
            if ((g.npc_cond ^ e.npc_cond) & m.npc_cond)
                report_field(name, "npc_cond", g.npc_cond, e.npc_cond);
            if ((g.dm_size ^ e.dm_size) & m.dm_size)
                report_field(name, "dm_size", g.dm_size, e.dm_size);
            if ((g.grf_wd_sel ^ e.grf_wd_sel) & m.grf_wd_sel)
                report_field(name, "grf_wd_sel", g.grf_wd_sel, e.grf_wd_sel);
            report_field(name, "dp_ctrl flags", g, e); // Whole struct for single-bit fields
        end
    endtask

    task automatic check_hazard(input hazard_info_t g, input hazard_info_t e,
                                input hazard_info_t m, input string name);
        if ((g ^ e) & m) begin
            hz_errors++;
            if ((g.t_use_rd2 ^ e.t_use_rd2) & m.t_use_rd2)
                report_field(name, "t_use_rd2", g.t_use_rd2, e.t_use_rd2);
            if ((g.t_new ^ e.t_new) & m.t_new) report_field(name, "t_new", g.t_new, e.t_new);
            if ((g.target ^ e.target) & m.target) report_field(name, "target", g.target, e.target);
            if ((g.fwd_e ^ e.fwd_e) & m.fwd_e) report_field(name, "fwd_e", g.fwd_e, e.fwd_e);
        end
    endtask

    task automatic check_exc(input exc_t g, input exc_t e, input exc_t m, input string name);
        if ((g ^ e) & m) begin
            exc_errors++;
            if (g.exception !== e.exception)
                report_field(name, "exception", g.exception, e.exception);
            else
                report_field(name, "exc_code", g.exc_code, e.exc_code);
        end
    endtask

    task automatic run_word(input insn_t w, input id_e id, input datapath_ctrl_t dp_mask);
        hazard_info_t e_hz;
        hazard_info_t m_hz;
        exc_t         e_exc;
        exc_t         m_exc;
        string        name;
        hazard_rule(id, w, e_hz, m_hz);
        e_exc.exception = (id == i_none) || (id == i_syscall);
        e_exc.exc_code  = (id == i_syscall) ? `CTRL_EXC_SYSCALL : `CTRL_EXC_RI;
        m_exc = e_exc.exception ? 6'h3f : 6'h20;
        name = $sformatf("%s %h", id.name(), w);
        wait (rst_n);
        @(negedge clk);
        insn = w;
        @(posedge clk);
        check_dp(dp_ctrl, dp_rule(id), dp_mask, name);
        check_hazard(hazard, e_hz, m_hz, name);
        check_exc(exc, e_exc, m_exc, name);
    endtask

    task automatic run_group(input id_e ids[$], input datapath_ctrl_t dp_mask);
        for (int k = 0; k < REPEATS; k++) begin
            foreach (ids[i]) run_word(make_word(ids[i]), ids[i], dp_mask);
        end
    endtask

    task automatic test_alu();
        datapath_ctrl_t m;
        m = '0;
        m.alu_op = DP_ONES.alu_op;
        m.alu_b_sel = DP_ONES.alu_b_sel;
        m.alu_sa_sel = DP_ONES.alu_sa_sel;
        m.ext_signed = 1'b1;
        m.alu_overflow_chk = 1'b1;
        m.grf_we = 1'b1;
        run_group('{i_add, i_sub, i_and, i_or, i_sll, i_addi, i_andi, i_ori, i_lui}, m);
    endtask

    task automatic test_memory();
        datapath_ctrl_t m;
        m = '0;
        m.alu_op = DP_ONES.alu_op;
        m.dm_size = DP_ONES.dm_size;
        m.grf_wd_sel = DP_ONES.grf_wd_sel;
        m.dm_we = 1'b1;
        m.dm_ext_signed = 1'b1;
        m.grf_we = 1'b1;
        run_group('{i_lw, i_lh, i_lb, i_sw, i_sh, i_sb}, m);
    endtask

    task automatic test_control_flow();
        datapath_ctrl_t m;
        m = '0;
        m.npc_op = DP_ONES.npc_op;
        m.npc_cond = DP_ONES.npc_cond;
        m.grf_wd_sel = DP_ONES.grf_wd_sel;
        m.grf_we = 1'b1;
        run_group('{i_beq, i_bne, i_jal, i_jr}, m);
    endtask

    task automatic test_set_muldiv();
        datapath_ctrl_t m;
        m = '0;
        m.cmp_signed = 1'b1;
        m.md_start = 1'b1;
        m.md_signed = 1'b1;
        m.md_write_hi = 1'b1;
        m.read_hi = 1'b1;
        m.read_lo = 1'b1;
        m.grf_we = 1'b1;
        run_group('{i_slt, i_sltu, i_mult, i_multu, i_div, i_divu,
                    i_mthi, i_mtlo, i_mfhi, i_mflo}, m);
    endtask

    task automatic test_cp0_exceptions();
        datapath_ctrl_t m;
        insn_t          w;
        id_e            id;
        m = '0;
        m.grf_wd_sel = DP_ONES.grf_wd_sel;
        m.cp0_we = 1'b1;
        m.eret = 1'b1;
        m.grf_we = 1'b1;
        run_group('{i_mfc0, i_mtc0, i_eret, i_syscall}, m);
        // Known random words are checked for exc and hazard only
        for (int n = 0; n < N_RANDOM; n++) begin
            w = insn_t'($urandom);
            id = classify(w);
            run_word(w, id, (id == i_none) ? DP_ONES : datapath_ctrl_t'('0));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        insn = '0;
        void'($urandom(32'h77ea_feff));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_alu();
        test_memory();
        test_control_flow();
        test_set_muldiv();
        test_cp0_exceptions();
        $display("Errors: dp_ctrl %0d, hazard %0d, exc %0d", dp_errors, hz_errors, exc_errors);
        if (dp_errors + hz_errors + exc_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/ctrl_pkg.sv
hdl/insn_decode.sv
hdl/datapath_ctrl.sv
hdl/hazard_ctrl.sv
hdl/mips_ctrl.sv
testbench/tb_mips_ctrl.sv

//--- Bender.yml
package:
  name: mips_ctrl

export_include_dirs:
  - include

sources:
  - hdl/ctrl_pkg.sv
  - hdl/insn_decode.sv
  - hdl/datapath_ctrl.sv
  - hdl/hazard_ctrl.sv
  - hdl/mips_ctrl.sv
  - target: simulation
    files:
      - testbench/tb_mips_ctrl.sv
